// ==== source/vcp_cfg_pkg.sv ====
package vcp_cfg_pkg;

	////////////////////
	// vector unit sizes
	////////////////////

	localparam int NUM_VREGS  = 8;                      // architectural vector registers
	localparam int NUM_LANES  = 4;                      // elements per register
	localparam int ELEM_W     = 32;                     // bits per element
	localparam int VREG_IDX_W = $clog2(NUM_VREGS);      // register index width
	localparam int VL_W       = $clog2(NUM_LANES + 1);  // holds 0 .. NUM_LANES
	localparam int LANE_IDX_W = $clog2(NUM_LANES);      // element select for extract

	////////////////////
	// base types
	////////////////////

	typedef logic [ELEM_W-1:0]     elem_t;       // one lane element
	typedef logic [VREG_IDX_W-1:0] vreg_idx_t;   // vector register number
	typedef logic [VL_W-1:0]       vl_t;         // current vector length
	typedef logic [NUM_LANES-1:0]  lane_mask_t;  // one enable per lane

	// whole register, lane 0 in the low bits
	typedef elem_t [NUM_LANES-1:0] vreg_t;

endpackage

// ==== source/vcp_isa_pkg.sv ====
package vcp_isa_pkg;

	import vcp_cfg_pkg::*;

	////////////////////
	// operation codes
	////////////////////

	typedef enum logic [3:0] {
		VADD_VV = 4'h0,  // vd = vs1 + vs2
		VSUB_VV = 4'h1,  // vd = vs1 - vs2
		VAND_VV = 4'h2,  // vd = vs1 & vs2
		VOR_VV  = 4'h3,  // vd = vs1 | vs2
		VXOR_VV = 4'h4,  // vd = vs1 ^ vs2
		VADD_VX = 4'h5,  // vd = vs2 + rs1
		VMV_VX  = 4'h6,  // vd = rs1 in every lane
		VSETVL  = 4'h7,  // vl = min(rs1, lanes)
		VEXT_XV = 4'h8   // result = vs2[rs1 % lanes]
	} vop_e;

	localparam vl_t VL_RESET = vl_t'(NUM_LANES);  // full length out of reset

	////////////////////
	// stage payloads
	////////////////////

	// decode -> register read
	typedef struct packed {
		vop_e       op;
		vreg_idx_t  vd;
		vreg_idx_t  vs1;
		vreg_idx_t  vs2;
		elem_t      scalar;  // rs1 value
		lane_mask_t mask;    // lanes below vl
		vl_t        new_vl;  // only meaningful for VSETVL
	} issue_t;

	// register read -> lanes
	typedef struct packed {
		vop_e       op;
		vreg_idx_t  vd;
		lane_mask_t mask;
		vreg_t      a;       // vs1 contents
		vreg_t      b;       // vs2 contents
		elem_t      scalar;
		vl_t        new_vl;
	} exec_t;

endpackage

// ==== source/vcp_stage_buf.sv ====
`timescale 1ns/1ps

module vcp_stage_buf #(
	parameter type T = logic  // stage payload
) (
	input  logic clk_i,
	input  logic rstn_i,
	// write side
	input  logic in_valid_i,
	output logic in_ready_o,
	input  T     in_data_i,
	// read side
	output logic out_valid_o,
	input  logic out_ready_i,
	output T     out_data_o
);

	logic full_q;  // entry occupied
	T     data_q;

	assign in_ready_o  = !full_q;  // one entry only
	assign out_valid_o = full_q;
	assign out_data_o  = data_q;

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			full_q <= 1'b0;
		end else begin
			if (in_valid_i && in_ready_o) full_q <= 1'b1;  // write
			else if (out_ready_i && full_q) full_q <= 1'b0;  // read
		end
	end

	always_ff @(posedge clk_i) begin
		if (in_valid_i && in_ready_o) data_q <= in_data_i;
	end

	// a writer held off by a full entry keeps its payload
	a_no_write_when_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
		in_valid_i && full_q |=> in_valid_i && $stable(in_data_i));

endmodule

// ==== source/vcp_ctrl.sv ====
`timescale 1ns/1ps

module vcp_ctrl (
	input  logic                   clk_i,
	input  logic                   rstn_i,
	// cpu handshake
	input  logic                   req_i,
	input  vcp_isa_pkg::vop_e      op_i,
	input  vcp_cfg_pkg::vreg_idx_t vd_i,
	input  vcp_cfg_pkg::vreg_idx_t vs1_i,
	input  vcp_cfg_pkg::vreg_idx_t vs2_i,
	input  vcp_cfg_pkg::elem_t     rs1_i,
	// launch into decode
	output logic                   launch_valid_o,
	input  logic                   launch_ready_i,
	output vcp_isa_pkg::vop_e      op_o,
	output vcp_cfg_pkg::vreg_idx_t vd_o,
	output vcp_cfg_pkg::vreg_idx_t vs1_o,
	output vcp_cfg_pkg::vreg_idx_t vs2_o,
	output vcp_cfg_pkg::elem_t     scalar_o,
	// completion from lanes
	input  logic                   done_i,
	input  vcp_cfg_pkg::elem_t     done_result_i,
	output logic                   ack_o,
	output vcp_cfg_pkg::elem_t     result_o
);
	import vcp_cfg_pkg::*;
	import vcp_isa_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_LAUNCH, S_BUSY, S_ACK} state_e;

	state_e    state_q;
	vop_e      op_q;
	vreg_idx_t vd_q, vs1_q, vs2_q;
	elem_t     scalar_q;
	elem_t     result_q;  // held for the whole ack phase
	logic      accept;

	assign accept = (state_q == S_IDLE) && req_i && !ack_o;  // ack low in idle anyway

	////////////////////
	// sequencing fsm
	////////////////////
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			state_q  <= S_IDLE;
			result_q <= '0;
		end else begin
			case (state_q)
				S_IDLE:   if (accept) state_q <= S_LAUNCH;          // fields captured below
				S_LAUNCH: if (launch_ready_i) state_q <= S_BUSY;    // decode took it
				S_BUSY: begin
					if (done_i) begin
						state_q  <= S_ACK;                             // ack the cycle after done
						result_q <= done_result_i;
					end
				end
				S_ACK:    if (!req_i) state_q <= S_IDLE;            // cpu released
				default:  state_q <= S_IDLE;
			endcase
		end
	end

	// instruction fields, captured on acceptance
	always_ff @(posedge clk_i) begin
		if (accept) begin
			op_q     <= op_i;
			vd_q     <= vd_i;
			vs1_q    <= vs1_i;
			vs2_q    <= vs2_i;
			scalar_q <= rs1_i;
		end
	end

	assign launch_valid_o = (state_q == S_LAUNCH);
	assign op_o           = op_q;
	assign vd_o           = vd_q;
	assign vs1_o          = vs1_q;
	assign vs2_o          = vs2_q;
	assign scalar_o       = scalar_q;
	assign ack_o          = (state_q == S_ACK);
	assign result_o       = result_q;

	// the cpu keeps req up until ack has been raised
	a_ack_rise_with_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
		$rose(ack_o) |-> $past(req_i));

	// pipeline only finishes work that was launched
	a_done_in_busy: assert property (@(posedge clk_i) disable iff (!rstn_i)
		done_i |-> state_q == S_BUSY);

endmodule

// ==== source/vcp_decode.sv ====
`timescale 1ns/1ps

module vcp_decode (
	input  logic                   clk_i,
	input  logic                   rstn_i,
	input  logic                   in_valid_i,
	output logic                   in_ready_o,
	input  vcp_isa_pkg::vop_e      op_i,
	input  vcp_cfg_pkg::vreg_idx_t vd_i,
	input  vcp_cfg_pkg::vreg_idx_t vs1_i,
	input  vcp_cfg_pkg::vreg_idx_t vs2_i,
	input  vcp_cfg_pkg::elem_t     scalar_i,
	output logic                   out_valid_o,
	input  logic                   out_ready_i,
	output vcp_isa_pkg::issue_t    out_data_o
);
	import vcp_cfg_pkg::*;
	import vcp_isa_pkg::*;

	vl_t        vl_q;         // architectural vector length
	logic       out_valid_q;
	issue_t     out_data_q;
	issue_t     dec;          // next payload
	lane_mask_t vl_mask;
	logic       accept, leave;

	assign in_ready_o = !out_valid_q || out_ready_i;  // empty or draining
	assign accept     = in_valid_i && in_ready_o;
	assign leave      = out_valid_q && out_ready_i;

	always_comb begin
		for (int k = 0; k < NUM_LANES; k++) begin
			vl_mask[k] = (k < int'(vl_q));  // tail lanes stay untouched
		end
		dec.op     = op_i;
		dec.vd     = vd_i;
		dec.vs1    = vs1_i;
		dec.vs2    = vs2_i;
		dec.scalar = scalar_i;
		dec.mask   = vl_mask;
		dec.new_vl = vl_q;  // unchanged unless setvl
		case (op_i)
			VSETVL: begin
				dec.mask = '0;  // no register write
				if (scalar_i >= elem_t'(NUM_LANES)) dec.new_vl = vl_t'(NUM_LANES);
				else dec.new_vl = vl_t'(scalar_i);  // clamp to lane count
			end
			VEXT_XV: dec.mask = '0;  // scalar result only
			default: ;
		endcase
	end

	////////////////////
	// vl and valid
	////////////////////
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			vl_q        <= VL_RESET;
			out_valid_q <= 1'b0;
		end else begin
			if (leave && out_data_q.op == VSETVL) vl_q <= out_data_q.new_vl;  // on exit
			if (accept) out_valid_q <= 1'b1;
			else if (leave) out_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) out_data_q <= dec;
	end

	assign out_valid_o = out_valid_q;
	assign out_data_o  = out_data_q;

endmodule

// ==== source/vcp_vrf.sv ====
`timescale 1ns/1ps

module vcp_vrf (
	input  logic                   clk_i,
	input  logic                   rstn_i,
	// operand read
	input  logic                   in_valid_i,
	output logic                   in_ready_o,
	input  vcp_isa_pkg::issue_t    in_data_i,
	output logic                   out_valid_o,
	input  logic                   out_ready_i,
	output vcp_isa_pkg::exec_t     out_data_o,
	// writeback from lanes
	input  logic                   wb_en_i,
	input  vcp_cfg_pkg::vreg_idx_t wb_vd_i,
	input  vcp_cfg_pkg::lane_mask_t wb_mask_i,
	input  vcp_cfg_pkg::vreg_t     wb_data_i
);
	import vcp_cfg_pkg::*;
	import vcp_isa_pkg::*;

	vreg_t regs_q [NUM_VREGS];  // register storage
	logic  out_valid_q;
	exec_t out_data_q;
	logic  accept;

	assign in_ready_o = !out_valid_q || out_ready_i;
	assign accept     = in_valid_i && in_ready_o;

	////////////////////
	// register array
	////////////////////
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			for (int r = 0; r < NUM_VREGS; r++) begin
				regs_q[r] <= '0;  // all registers start at zero
			end
		end else if (wb_en_i) begin
			for (int k = 0; k < NUM_LANES; k++) begin
				if (wb_mask_i[k]) regs_q[wb_vd_i][k] <= wb_data_i[k];  // masked lanes only
			end
		end
	end

	////////////////////
	// operand read
	////////////////////
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			out_valid_q <= 1'b0;
		end else begin
			if (accept) out_valid_q <= 1'b1;
			else if (out_ready_i) out_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			out_data_q.op     <= in_data_i.op;
			out_data_q.vd     <= in_data_i.vd;
			out_data_q.mask   <= in_data_i.mask;
			out_data_q.a      <= regs_q[in_data_i.vs1];
			out_data_q.b      <= regs_q[in_data_i.vs2];
			out_data_q.scalar <= in_data_i.scalar;
			out_data_q.new_vl <= in_data_i.new_vl;
		end
	end

	assign out_valid_o = out_valid_q;
	assign out_data_o  = out_data_q;

endmodule

// ==== source/vcp_lane_alu.sv ====
`timescale 1ns/1ps

module vcp_lane_alu (
	input  logic                    clk_i,
	input  logic                    rstn_i,
	input  logic                    in_valid_i,
	output logic                    in_ready_o,
	input  vcp_isa_pkg::exec_t      in_data_i,
	// register file write port
	output logic                    wb_en_o,
	output vcp_cfg_pkg::vreg_idx_t  wb_vd_o,
	output vcp_cfg_pkg::lane_mask_t wb_mask_o,
	output vcp_cfg_pkg::vreg_t      wb_data_o,
	// completion to controller
	output logic                    done_o,
	output vcp_cfg_pkg::elem_t      result_o
);
	import vcp_cfg_pkg::*;
	import vcp_isa_pkg::*;

	vreg_t      lane_res;     // per-lane result
	elem_t      scalar_res;
	logic       writes_vreg;
	logic       done_q, wb_en_q;
	vreg_idx_t  wb_vd_q;
	lane_mask_t wb_mask_q;
	vreg_t      wb_data_q;
	elem_t      result_q;

	assign in_ready_o = 1'b1;  // output regs free every cycle

	////////////////////
	// simd lanes
	////////////////////
	always_comb begin
		for (int k = 0; k < NUM_LANES; k++) begin
			case (in_data_i.op)
				VADD_VV: lane_res[k] = in_data_i.a[k] + in_data_i.b[k];  // wraps at 32 bits
				VSUB_VV: lane_res[k] = in_data_i.a[k] - in_data_i.b[k];  // vs1 - vs2
				VAND_VV: lane_res[k] = in_data_i.a[k] & in_data_i.b[k];
				VOR_VV:  lane_res[k] = in_data_i.a[k] | in_data_i.b[k];
				VXOR_VV: lane_res[k] = in_data_i.a[k] ^ in_data_i.b[k];
				VADD_VX: lane_res[k] = in_data_i.b[k] + in_data_i.scalar;
				VMV_VX:  lane_res[k] = in_data_i.scalar;  // splat
				default: lane_res[k] = in_data_i.b[k];    // not written back
			endcase
		end
	end

	// scalar side
	always_comb begin
		case (in_data_i.op)
			VSETVL:  scalar_res = elem_t'(in_data_i.new_vl);  // zero-extended
			VEXT_XV: scalar_res = in_data_i.b[in_data_i.scalar[LANE_IDX_W-1:0]];
			default: scalar_res = '0;
		endcase
	end

	assign writes_vreg = (in_data_i.op != VSETVL) && (in_data_i.op != VEXT_XV);

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			done_q  <= 1'b0;
			wb_en_q <= 1'b0;
		end else begin
			done_q  <= in_valid_i;                 // one pulse per instruction
			wb_en_q <= in_valid_i && writes_vreg;
		end
	end

	always_ff @(posedge clk_i) begin
		if (in_valid_i) begin
			wb_vd_q   <= in_data_i.vd;
			wb_mask_q <= in_data_i.mask;
			wb_data_q <= lane_res;
			result_q  <= scalar_res;
		end
	end

	assign wb_en_o   = wb_en_q;
	assign wb_vd_o   = wb_vd_q;
	assign wb_mask_o = wb_mask_q;
	assign wb_data_o = wb_data_q;
	assign done_o    = done_q;
	assign result_o  = result_q;

	// scalar-only operations arrive with every lane disabled
	a_scalar_op_no_lanes: assert property (@(posedge clk_i) disable iff (!rstn_i)
		in_valid_i && !writes_vreg |-> in_data_i.mask == '0);

endmodule

// ==== source/vcp_top.sv ====
`timescale 1ns/1ps

module vcp_top (
	input  logic                   clk_i,
	input  logic                   rstn_i,
	input  logic                   req_i,
	input  vcp_isa_pkg::vop_e      op_i,
	input  vcp_cfg_pkg::vreg_idx_t vd_i,
	input  vcp_cfg_pkg::vreg_idx_t vs1_i,
	input  vcp_cfg_pkg::vreg_idx_t vs2_i,
	input  vcp_cfg_pkg::elem_t     rs1_i,
	output logic                   ack_o,
	output vcp_cfg_pkg::elem_t     result_o
);
	import vcp_cfg_pkg::*;
	import vcp_isa_pkg::*;

	logic       launch_valid, launch_ready;  // ctrl -> decode
	vop_e       launch_op;
	vreg_idx_t  launch_vd, launch_vs1, launch_vs2;
	elem_t      launch_scalar;
	logic       dec_valid, dec_ready;        // decode -> issue buffer
	issue_t     dec_data;
	logic       iss_valid, iss_ready;        // issue buffer -> vrf
	issue_t     iss_data;
	logic       rd_valid, rd_ready;          // vrf -> exec buffer
	exec_t      rd_data;
	logic       ex_valid, ex_ready;          // exec buffer -> lanes
	exec_t      ex_data;
	logic       wb_en;                       // lanes -> vrf
	vreg_idx_t  wb_vd;
	lane_mask_t wb_mask;
	vreg_t      wb_data;
	logic       done;                        // lanes -> ctrl
	elem_t      done_result;

	////////////////////
	// control
	////////////////////
	vcp_ctrl u_ctrl (
		.clk_i         (clk_i),         .rstn_i        (rstn_i),
		.req_i         (req_i),         .op_i          (op_i),
		.vd_i          (vd_i),          .vs1_i         (vs1_i),
		.vs2_i         (vs2_i),         .rs1_i         (rs1_i),
		.launch_valid_o(launch_valid),  .launch_ready_i(launch_ready),
		.op_o          (launch_op),     .vd_o          (launch_vd),
		.vs1_o         (launch_vs1),    .vs2_o         (launch_vs2),
		.scalar_o      (launch_scalar), .done_i        (done),
		.done_result_i (done_result),   .ack_o         (ack_o),
		.result_o      (result_o)
	);

	////////////////////
	// pipeline
	////////////////////
	vcp_decode u_decode (
		.clk_i      (clk_i),        .rstn_i     (rstn_i),
		.in_valid_i (launch_valid), .in_ready_o (launch_ready),
		.op_i       (launch_op),    .vd_i       (launch_vd),
		.vs1_i      (launch_vs1),   .vs2_i      (launch_vs2),
		.scalar_i   (launch_scalar),
		.out_valid_o(dec_valid),    .out_ready_i(dec_ready),  .out_data_o(dec_data)
	);

	vcp_stage_buf #(.T(issue_t)) u_issue_buf (
		.clk_i      (clk_i),     .rstn_i     (rstn_i),
		.in_valid_i (dec_valid), .in_ready_o (dec_ready), .in_data_i (dec_data),
		.out_valid_o(iss_valid), .out_ready_i(iss_ready), .out_data_o(iss_data)
	);

	vcp_vrf u_vrf (
		.clk_i      (clk_i),     .rstn_i     (rstn_i),
		.in_valid_i (iss_valid), .in_ready_o (iss_ready), .in_data_i (iss_data),
		.out_valid_o(rd_valid),  .out_ready_i(rd_ready),  .out_data_o(rd_data),
		.wb_en_i    (wb_en),     .wb_vd_i    (wb_vd),
		.wb_mask_i  (wb_mask),   .wb_data_i  (wb_data)
	);

	vcp_stage_buf #(.T(exec_t)) u_exec_buf (
		.clk_i      (clk_i),    .rstn_i     (rstn_i),
		.in_valid_i (rd_valid), .in_ready_o (rd_ready), .in_data_i (rd_data),
		.out_valid_o(ex_valid), .out_ready_i(ex_ready), .out_data_o(ex_data)
	);

	vcp_lane_alu u_lane_alu (
		.clk_i     (clk_i),    .rstn_i    (rstn_i),
		.in_valid_i(ex_valid), .in_ready_o(ex_ready), .in_data_i(ex_data),
		.wb_en_o   (wb_en),    .wb_vd_o   (wb_vd),
		.wb_mask_o (wb_mask),  .wb_data_o (wb_data),
		.done_o    (done),     .result_o  (done_result)
	);

endmodule

// ==== test/tb_vcp_model.svh ====
`ifndef TB_VCP_MODEL_SVH
`define TB_VCP_MODEL_SVH

////////////////////
// reference model
////////////////////

logic [31:0] mdl_regs [NUM_VREGS][NUM_LANES];  // model register file
int          mdl_vl;                           // model vector length

task automatic model_reset();
	for (int r = 0; r < NUM_VREGS; r++) begin
		for (int k = 0; k < NUM_LANES; k++) begin
			mdl_regs[r][k] = '0;  // registers start cleared
		end
	end
	mdl_vl = NUM_LANES;  // full length after reset
endtask

// applies one instruction to the model, returns the scalar result
function automatic logic [31:0] exp_result(vop_e op, int vd, int vs1, int vs2,
		logic [31:0] rs1);
	logic [31:0] a [NUM_LANES];
	logic [31:0] b [NUM_LANES];
	logic [31:0] r;
	int          idx;
	for (int k = 0; k < NUM_LANES; k++) begin
		a[k] = mdl_regs[vs1][k];  // read before any write, vd may alias
		b[k] = mdl_regs[vs2][k];
	end
	case (op)
		VSETVL: begin
			mdl_vl = (rs1 > NUM_LANES) ? NUM_LANES : int'(rs1);  // clamp
			return 32'(mdl_vl);
		end
		VEXT_XV: begin
			idx = int'(rs1 % NUM_LANES);  // element select wraps
			return b[idx];
		end
		default: begin
			for (int k = 0; k < mdl_vl; k++) begin  // tail lanes kept
				case (op)
					VADD_VV: r = a[k] + b[k];
					VSUB_VV: r = a[k] - b[k];
					VAND_VV: r = a[k] & b[k];
					VOR_VV:  r = a[k] | b[k];
					VXOR_VV: r = a[k] ^ b[k];
					VADD_VX: r = b[k] + rs1;
					default: r = rs1;  // splat
				endcase
				mdl_regs[vd][k] = r;
			end
			return '0;  // no scalar result
		end
	endcase
endfunction

`endif

// ==== test/tb_vcp.sv ====
`timescale 1ns/1ps

module tb_vcp;
	import vcp_cfg_pkg::*;
	import vcp_isa_pkg::*;

	localparam int ACK_TIMEOUT = 50;   // cycles allowed per ack edge
	localparam int NUM_RANDOM  = 200;

	logic      clk_i, rstn_i, req_i, ack_o;
	vop_e      op_i;
	vreg_idx_t vd_i, vs1_i, vs2_i;
	elem_t     rs1_i, result_o;

	elem_t     exp_q [$];     // expected results, issue order
	elem_t     held_result;   // result_o at ack rise
	logic      ack_prev;
	int        num_issued, num_checked;

	`include "tb_vcp_model.svh"

	vcp_top UUT (
		.clk_i   (clk_i),
		.rstn_i  (rstn_i),
		.req_i   (req_i),
		.op_i    (op_i),
		.vd_i    (vd_i),
		.vs1_i   (vs1_i),
		.vs2_i   (vs2_i),
		.rs1_i   (rs1_i),
		.ack_o   (ack_o),
		.result_o(result_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;  // 8 ns period
	end

	task automatic stop_run(string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	////////////////////
	// compare process
	////////////////////
	always @(negedge clk_i) begin
		if (!rstn_i) begin
			ack_prev = 1'b0;
		end else begin
			if (ack_o && !ack_prev) begin
				assert (exp_q.size() > 0) else stop_run("ack_o rose with no request outstanding");
				assert (req_i) else stop_run("ack_o rose while req_i was low");
				assert (result_o == exp_q[0]) else
					stop_run($sformatf("ERR result_o expected %h got %h", exp_q[0], result_o));
				held_result = result_o;
				void'(exp_q.pop_front());
				num_checked++;
			end else if (ack_o) begin
				assert (result_o == held_result) else  // must not move during ack
					stop_run($sformatf("ERR result_o expected %h got %h", held_result, result_o));
			end else if (ack_prev) begin
				assert (!req_i) else stop_run("ack_o fell while req_i was still high");
			end
			ack_prev = ack_o;
		end
	end

	////////////////////
	// handshake driver
	////////////////////
	task automatic run_instr(vop_e op, vreg_idx_t vd, vreg_idx_t vs1, vreg_idx_t vs2,
			elem_t rs1, int hold);
		int waited;
		@(posedge clk_i);
		#1;
		exp_q.push_back(exp_result(op, int'(vd), int'(vs1), int'(vs2), rs1));
		num_issued++;
		op_i  = op;
		vd_i  = vd;
		vs1_i = vs1;
		vs2_i = vs2;
		rs1_i = rs1;
		req_i = 1'b1;
		waited = 0;
		while (ack_o !== 1'b1) begin
			@(negedge clk_i);
			waited++;
			assert (waited <= ACK_TIMEOUT) else stop_run("timeout waiting for ack_o to rise");
		end
		repeat (hold) @(negedge clk_i);  // keep req up, ack must stay
		@(posedge clk_i);
		#1;
		req_i = 1'b0;
		waited = 0;
		while (ack_o !== 1'b0) begin
			@(negedge clk_i);
			waited++;
			assert (waited <= ACK_TIMEOUT) else stop_run("timeout waiting for ack_o to fall");
		end
	endtask

	function automatic vreg_idx_t rand_reg();
		return vreg_idx_t'($urandom_range(0, NUM_VREGS - 1));
	endfunction

	task automatic run_random(vop_e op);
		elem_t rs1;
		rs1 = (op == VSETVL) ? elem_t'($urandom_range(0, 6)) : elem_t'($urandom());
		run_instr(op, rand_reg(), rand_reg(), rand_reg(), rs1, int'($urandom_range(0, 2)));
	endtask

	// every lane of every register through extract
	task automatic read_all_regs();
		for (int r = 0; r < NUM_VREGS; r++) begin
			for (int k = 0; k < NUM_LANES; k++) begin
				run_instr(VEXT_XV, '0, '0, vreg_idx_t'(r), elem_t'(k), 0);
			end
		end
	endtask

	initial begin
		vop_e  ops [9];
		elem_t vl_vals [3];
		void'($urandom(45));
		ops = '{VADD_VV, VSUB_VV, VAND_VV, VOR_VV, VXOR_VV, VADD_VX, VMV_VX, VSETVL, VEXT_XV};
		vl_vals = '{32'd0, 32'd2, 32'd7};
		rstn_i = 1'b0;
		req_i  = 1'b0;
		op_i   = VADD_VV;
		vd_i   = '0;
		vs1_i  = '0;
		vs2_i  = '0;
		rs1_i  = '0;
		num_issued  = 0;
		num_checked = 0;
		model_reset();
		repeat (8) @(posedge clk_i);
		#1;
		rstn_i = 1'b1;

		repeat (3) begin  // idle, no ack yet
			@(negedge clk_i);
			assert (ack_o === 1'b0) else
				stop_run($sformatf("ERR ack_o expected %h got %h", 1'b0, ack_o));
		end
		read_all_regs();  // all zero out of reset

		////////////////////
		// splat and arithmetic
		////////////////////
		for (int r = 0; r < NUM_VREGS; r++) begin
			run_instr(VMV_VX, vreg_idx_t'(r), '0, '0, $urandom(), 1);
		end
		for (int i = 0; i < 12; i++) begin
			run_random(ops[i % 6]);  // vv ops and vadd_vx, twice each
		end
		read_all_regs();

		// short vector lengths, tails must hold
		foreach (vl_vals[i]) begin
			run_instr(VSETVL, '0, '0, '0, vl_vals[i], 2);
			run_random(VMV_VX);
			run_random(VADD_VV);
			run_random(VXOR_VV);
			read_all_regs();
		end
		run_instr(VSETVL, '0, '0, '0, elem_t'(NUM_LANES), 0);

		for (int i = 0; i < NUM_RANDOM; i++) begin
			run_random(ops[$urandom_range(0, 8)]);
		end
		read_all_regs();

		if (num_checked == num_issued && exp_q.size() == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			stop_run($sformatf("only %0d of %0d results were compared", num_checked, num_issued));
		end
	end

endmodule

// ==== build.f ====
+incdir+test
source/vcp_cfg_pkg.sv
source/vcp_isa_pkg.sv
source/vcp_stage_buf.sv
source/vcp_ctrl.sv
source/vcp_decode.sv
source/vcp_vrf.sv
source/vcp_lane_alu.sv
source/vcp_top.sv
test/tb_vcp.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_vcp
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
